//--- dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    localparam int addr_width     = 32;
    localparam int word_width     = 32;
    localparam int words_per_line = 8;
    localparam int offset_width   = 5;
    localparam int index_width    = 6;
    localparam int tag_width      = addr_width - index_width - offset_width;
    localparam int way_count      = 2;

    // Derived geometry
    localparam int set_count      = 1 << index_width;
    localparam int line_width     = words_per_line * word_width;
    localparam int byte_sel_width = 2;

    typedef logic [addr_width-1:0]                     addr_t;
    typedef logic [word_width-1:0]                     word_t;
    typedef logic [word_width/8-1:0]                   strb_t;
    typedef logic [line_width-1:0]                     line_t;
    typedef logic [line_width/8-1:0]                   line_strb_t;
    typedef logic [index_width-1:0]                    index_t;
    typedef logic [tag_width-1:0]                      tag_t;
    typedef logic [offset_width-byte_sel_width-1:0]    word_sel_t;
    typedef logic [$clog2(way_count)-1:0]              way_t;

    typedef enum logic [1:0] {
        idle,
        writeback,
        fetch,
        install
    } refill_state_t;

endpackage

`default_nettype wire

//--- dcache_way_ram.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_way_ram
    import dcache_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  index_t     rd_index,
    input  logic       fill_valid,
    input  index_t     fill_index,
    input  tag_t       fill_tag,
    input  line_t      fill_line,
    input  logic       wr_valid,
    input  index_t     wr_index,
    input  line_t      wr_line,
    input  line_strb_t wr_word_strb,
    input  logic       set_dirty,
    output tag_t       rd_tag,
    output logic       rd_valid_bit,
    output logic       rd_dirty,
    output line_t      rd_line
);

    tag_t                 tag_mem  [set_count];
    line_t                data_mem [set_count];
    logic [set_count-1:0] valid_mem;
    logic [set_count-1:0] dirty_mem;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_mem    <= '0;
            dirty_mem    <= '0;
            rd_valid_bit <= 1'b0;
            rd_dirty     <= 1'b0;
        end else begin
            rd_valid_bit <= valid_mem[rd_index];
            rd_dirty     <= dirty_mem[rd_index];
            if (fill_valid) begin
                valid_mem[fill_index] <= 1'b1;
                dirty_mem[fill_index] <= 1'b0;
            end else if (wr_valid && set_dirty) begin
                dirty_mem[wr_index] <= 1'b1;
            end
        end
    end

    // A fill replaces the whole line, a store touches only its strobed bytes
    always_ff @(posedge clk) begin
        rd_tag  <= tag_mem[rd_index];
        rd_line <= data_mem[rd_index];
        if (fill_valid) begin
            tag_mem[fill_index]  <= fill_tag;
            data_mem[fill_index] <= fill_line;
        end else if (wr_valid) begin
            for (int b = 0; b < line_width / 8; b++) begin
                if (wr_word_strb[b]) begin
                    data_mem[wr_index][b*8 +: 8] <= wr_line[b*8 +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- dcache_request_stage.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_request_stage
    import dcache_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   req_valid,
    input  logic   req_write,
    input  addr_t  req_addr,
    input  word_t  req_wdata,
    input  strb_t  req_wstrb,
    input  logic   miss,
    input  logic   refill_busy,
    input  logic   fill_done,
    output logic   req_ready,
    output index_t rd_index,
    output logic   s1_valid,
    output logic   s1_write,
    output addr_t  s1_addr,
    output word_t  s1_wdata,
    output strb_t  s1_wstrb
);

    logic accept;
    logic store_block;
    logic replay;

    assign req_ready = !(miss || refill_busy || store_block || replay);
    assign accept    = req_valid && req_ready;

    // The replay cycle rereads the held request once the new line is in the array
    assign rd_index = replay ? s1_addr[offset_width +: index_width]
                             : req_addr[offset_width +: index_width];

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid    <= 1'b0;
            store_block <= 1'b0;
            replay      <= 1'b0;
        end else begin
            s1_valid    <= accept || replay;
            store_block <= (accept && req_write) || (replay && s1_write);
            replay      <= fill_done;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s1_write <= req_write;
            s1_addr  <= req_addr;
            s1_wdata <= req_wdata;
            s1_wstrb <= req_wstrb;
        end
    end

endmodule

`default_nettype wire

//--- dcache_hit_stage.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_hit_stage
    import dcache_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       s1_valid,
    input  logic       s1_write,
    input  addr_t      s1_addr,
    input  word_t      s1_wdata,
    input  strb_t      s1_wstrb,
    input  tag_t       way0_rd_tag,
    input  logic       way0_rd_valid_bit,
    input  logic       way0_rd_dirty,
    input  line_t      way0_rd_line,
    input  tag_t       way1_rd_tag,
    input  logic       way1_rd_valid_bit,
    input  logic       way1_rd_dirty,
    input  line_t      way1_rd_line,
    input  logic       fill_done,
    output logic       resp_valid,
    output word_t      resp_rdata,
    output logic       miss,
    output addr_t      miss_addr,
    output way_t       victim_way,
    output logic       victim_dirty,
    output tag_t       victim_tag,
    output line_t      victim_line,
    output way_t       wr_way,
    output logic       wr_valid,
    output index_t     wr_index,
    output line_t      wr_line,
    output line_strb_t wr_word_strb,
    output logic       set_dirty
);

    index_t               s1_index;
    tag_t                 s1_tag;
    word_sel_t            s1_word;
    logic                 lookup;
    logic                 hit0;
    logic                 hit1;
    logic                 hit_any;
    line_t                hit_line;
    word_t                load_word;
    logic [set_count-1:0] lru;
    logic                 miss_wait;

    assign s1_index = s1_addr[offset_width +: index_width];
    assign s1_tag   = s1_addr[offset_width + index_width +: tag_width];
    assign s1_word  = s1_addr[offset_width-1:byte_sel_width];

    assign lookup  = s1_valid && !miss_wait;
    assign hit0    = way0_rd_valid_bit && (way0_rd_tag == s1_tag);
    assign hit1    = way1_rd_valid_bit && (way1_rd_tag == s1_tag);
    assign hit_any = hit0 || hit1;

    assign hit_line  = hit1 ? way1_rd_line : way0_rd_line;
    assign load_word = hit_line[{s1_word, 5'd0} +: word_width];

    // The LRU bit names the way to evict next
    assign victim_way   = lru[s1_index];
    assign victim_dirty = victim_way ? (way1_rd_valid_bit && way1_rd_dirty)
                                     : (way0_rd_valid_bit && way0_rd_dirty);
    assign victim_tag   = victim_way ? way1_rd_tag : way0_rd_tag;
    assign victim_line  = victim_way ? way1_rd_line : way0_rd_line;
    assign miss         = lookup && !hit_any;
    assign miss_addr    = s1_addr;

    assign wr_valid     = lookup && hit_any && s1_write;
    assign wr_way       = hit1;
    assign wr_index     = s1_index;
    assign wr_line      = {words_per_line{s1_wdata}};
    assign wr_word_strb = line_strb_t'(s1_wstrb) << {s1_word, 2'b00};
    assign set_dirty    = wr_valid && (|s1_wstrb);

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
            miss_wait  <= 1'b0;
            lru        <= '0;
        end else begin
            resp_valid <= lookup && hit_any;
            if (lookup && hit_any) begin
                lru[s1_index] <= !hit1;
            end
            if (miss) begin
                miss_wait <= 1'b1;
            end else if (fill_done) begin
                miss_wait <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lookup && hit_any) begin
            resp_rdata <= s1_write ? '0 : load_word;
        end
    end

endmodule

`default_nettype wire

//--- dcache_refill.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_refill
    import dcache_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   miss,
    input  addr_t  miss_addr,
    input  way_t   victim_way,
    input  logic   victim_dirty,
    input  tag_t   victim_tag,
    input  line_t  victim_line,
    input  logic   mem_rd_ack,
    input  line_t  mem_rd_line,
    input  logic   mem_wr_ack,
    output logic   refill_busy,
    output logic   mem_rd_req,
    output addr_t  mem_rd_addr,
    output logic   mem_wr_req,
    output addr_t  mem_wr_addr,
    output line_t  mem_wr_line,
    output logic   fill_valid,
    output way_t   fill_way,
    output index_t fill_index,
    output tag_t   fill_tag,
    output line_t  fill_line,
    output logic   fill_done
);

    refill_state_t state;

    assign refill_busy = (state != idle);
    assign mem_wr_req  = (state == writeback);
    assign mem_rd_req  = (state == fetch);
    assign fill_valid  = (state == install);
    assign fill_done   = (state == install);
    assign mem_rd_addr = {fill_tag, fill_index, {offset_width{1'b0}}};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (miss) begin
                        state <= victim_dirty ? writeback : fetch;
                    end
                end
                writeback: begin
                    if (mem_wr_ack) begin
                        state <= fetch;
                    end
                end
                fetch: begin
                    if (mem_rd_ack) begin
                        state <= install;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // Victim and target are captured in the miss cycle, before the arrays move on
    always_ff @(posedge clk) begin
        if (state == idle && miss) begin
            fill_way    <= victim_way;
            fill_index  <= miss_addr[offset_width +: index_width];
            fill_tag    <= miss_addr[offset_width + index_width +: tag_width];
            mem_wr_addr <= {victim_tag, miss_addr[offset_width +: index_width],
                            {offset_width{1'b0}}};
            mem_wr_line <= victim_line;
        end
        if (state == fetch && mem_rd_ack) begin
            fill_line <= mem_rd_line;
        end
    end

endmodule

`default_nettype wire

//--- dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top
    import dcache_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  req_valid,
    input  logic  req_write,
    input  addr_t req_addr,
    input  word_t req_wdata,
    input  strb_t req_wstrb,
    output logic  req_ready,
    output logic  resp_valid,
    output word_t resp_rdata,
    output logic  mem_rd_req,
    output addr_t mem_rd_addr,
    input  logic  mem_rd_ack,
    input  line_t mem_rd_line,
    output logic  mem_wr_req,
    output addr_t mem_wr_addr,
    output line_t mem_wr_line,
    input  logic  mem_wr_ack
);

    index_t     rd_index;
    logic       s1_valid;
    logic       s1_write;
    addr_t      s1_addr;
    word_t      s1_wdata;
    strb_t      s1_wstrb;
    logic       miss;
    addr_t      miss_addr;
    way_t       victim_way;
    logic       victim_dirty;
    tag_t       victim_tag;
    line_t      victim_line;
    way_t       wr_way;
    logic       wr_valid;
    index_t     wr_index;
    line_t      wr_line;
    line_strb_t wr_word_strb;
    logic       set_dirty;
    logic       refill_busy;
    logic       fill_valid;
    way_t       fill_way;
    index_t     fill_index;
    tag_t       fill_tag;
    line_t      fill_line;
    logic       fill_done;
    tag_t       way0_rd_tag;
    logic       way0_rd_valid_bit;
    logic       way0_rd_dirty;
    line_t      way0_rd_line;
    tag_t       way1_rd_tag;
    logic       way1_rd_valid_bit;
    logic       way1_rd_dirty;
    line_t      way1_rd_line;
    logic       way0_fill;
    logic       way1_fill;
    logic       way0_wr;
    logic       way1_wr;

    // Way enables for the shared fill and store write buses
    assign way0_fill = fill_valid && (fill_way == 1'b0);
    assign way1_fill = fill_valid && (fill_way == 1'b1);
    assign way0_wr   = wr_valid && (wr_way == 1'b0);
    assign way1_wr   = wr_valid && (wr_way == 1'b1);

    dcache_request_stage dcache_request_stage_inst (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req_write   (req_write),
        .req_addr    (req_addr),
        .req_wdata   (req_wdata),
        .req_wstrb   (req_wstrb),
        .miss        (miss),
        .refill_busy (refill_busy),
        .fill_done   (fill_done),
        .req_ready   (req_ready),
        .rd_index    (rd_index),
        .s1_valid    (s1_valid),
        .s1_write    (s1_write),
        .s1_addr     (s1_addr),
        .s1_wdata    (s1_wdata),
        .s1_wstrb    (s1_wstrb)
    );

    dcache_hit_stage dcache_hit_stage_inst (
        .clk               (clk),
        .rst               (rst),
        .s1_valid          (s1_valid),
        .s1_write          (s1_write),
        .s1_addr           (s1_addr),
        .s1_wdata          (s1_wdata),
        .s1_wstrb          (s1_wstrb),
        .way0_rd_tag       (way0_rd_tag),
        .way0_rd_valid_bit (way0_rd_valid_bit),
        .way0_rd_dirty     (way0_rd_dirty),
        .way0_rd_line      (way0_rd_line),
        .way1_rd_tag       (way1_rd_tag),
        .way1_rd_valid_bit (way1_rd_valid_bit),
        .way1_rd_dirty     (way1_rd_dirty),
        .way1_rd_line      (way1_rd_line),
        .fill_done         (fill_done),
        .resp_valid        (resp_valid),
        .resp_rdata        (resp_rdata),
        .miss              (miss),
        .miss_addr         (miss_addr),
        .victim_way        (victim_way),
        .victim_dirty      (victim_dirty),
        .victim_tag        (victim_tag),
        .victim_line       (victim_line),
        .wr_way            (wr_way),
        .wr_valid          (wr_valid),
        .wr_index          (wr_index),
        .wr_line           (wr_line),
        .wr_word_strb      (wr_word_strb),
        .set_dirty         (set_dirty)
    );

    dcache_refill dcache_refill_inst (
        .clk          (clk),
        .rst          (rst),
        .miss         (miss),
        .miss_addr    (miss_addr),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_line  (victim_line),
        .mem_rd_ack   (mem_rd_ack),
        .mem_rd_line  (mem_rd_line),
        .mem_wr_ack   (mem_wr_ack),
        .refill_busy  (refill_busy),
        .mem_rd_req   (mem_rd_req),
        .mem_rd_addr  (mem_rd_addr),
        .mem_wr_req   (mem_wr_req),
        .mem_wr_addr  (mem_wr_addr),
        .mem_wr_line  (mem_wr_line),
        .fill_valid   (fill_valid),
        .fill_way     (fill_way),
        .fill_index   (fill_index),
        .fill_tag     (fill_tag),
        .fill_line    (fill_line),
        .fill_done    (fill_done)
    );

    dcache_way_ram dcache_way_ram_0_inst (
        .clk          (clk),
        .rst          (rst),
        .rd_index     (rd_index),
        .fill_valid   (way0_fill),
        .fill_index   (fill_index),
        .fill_tag     (fill_tag),
        .fill_line    (fill_line),
        .wr_valid     (way0_wr),
        .wr_index     (wr_index),
        .wr_line      (wr_line),
        .wr_word_strb (wr_word_strb),
        .set_dirty    (set_dirty),
        .rd_tag       (way0_rd_tag),
        .rd_valid_bit (way0_rd_valid_bit),
        .rd_dirty     (way0_rd_dirty),
        .rd_line      (way0_rd_line)
    );

    dcache_way_ram dcache_way_ram_1_inst (
        .clk          (clk),
        .rst          (rst),
        .rd_index     (rd_index),
        .fill_valid   (way1_fill),
        .fill_index   (fill_index),
        .fill_tag     (fill_tag),
        .fill_line    (fill_line),
        .wr_valid     (way1_wr),
        .wr_index     (wr_index),
        .wr_line      (wr_line),
        .wr_word_strb (wr_word_strb),
        .set_dirty    (set_dirty),
        .rd_tag       (way1_rd_tag),
        .rd_valid_bit (way1_rd_valid_bit),
        .rd_dirty     (way1_rd_dirty),
        .rd_line      (way1_rd_line)
    );

endmodule

`default_nettype wire

//--- dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tb
    import dcache_pkg::*;
();

    logic  clk;
    logic  rst;
    logic  req_valid;
    logic  req_write;
    addr_t req_addr;
    word_t req_wdata;
    strb_t req_wstrb;
    logic  req_ready;
    logic  resp_valid;
    word_t resp_rdata;
    logic  mem_rd_req;
    addr_t mem_rd_addr;
    logic  mem_rd_ack;
    line_t mem_rd_line;
    logic  mem_wr_req;
    addr_t mem_wr_addr;
    line_t mem_wr_line;
    logic  mem_wr_ack;

    word_t  mem_model [addr_t];
    integer seed = 29094;
    int     errors = 0;
    int     cycle_count = 0;
    int     wb_count = 0;
    int     req_count = 0;
    int     resp_count = 0;

    // One entry per accepted request, popped when its response arrives
    word_t exp_rdata [$];
    bit    exp_hit [$];
    int    exp_wb [$];
    int    exp_cycle [$];

    dcache_top dcache_top_inst (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req_write   (req_write),
        .req_addr    (req_addr),
        .req_wdata   (req_wdata),
        .req_wstrb   (req_wstrb),
        .req_ready   (req_ready),
        .resp_valid  (resp_valid),
        .resp_rdata  (resp_rdata),
        .mem_rd_req  (mem_rd_req),
        .mem_rd_addr (mem_rd_addr),
        .mem_rd_ack  (mem_rd_ack),
        .mem_rd_line (mem_rd_line),
        .mem_wr_req  (mem_wr_req),
        .mem_wr_addr (mem_wr_addr),
        .mem_wr_line (mem_wr_line),
        .mem_wr_ack  (mem_wr_ack)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("error at %0t: %s is 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
        end
    endtask

    // A word that was never written holds its own word-aligned address
    function automatic line_t fetch_line(input addr_t line_addr);
        line_t line;
        addr_t word_addr;
        for (int w = 0; w < words_per_line; w++) begin
            word_addr = {line_addr[addr_width-1:offset_width], word_sel_t'(w), 2'b00};
            if (mem_model.exists(word_addr)) begin
                line[w*word_width +: word_width] = mem_model[word_addr];
            end else begin
                line[w*word_width +: word_width] = word_addr;
            end
        end
        return line;
    endfunction

    task automatic store_line(input addr_t line_addr, input line_t line);
        addr_t word_addr;
        for (int w = 0; w < words_per_line; w++) begin
            word_addr = {line_addr[addr_width-1:offset_width], word_sel_t'(w), 2'b00};
            mem_model[word_addr] = line[w*word_width +: word_width];
        end
    endtask

    // Each memory request is acknowledged after 0 to 3 random cycles
    initial begin
        int  rd_delay;
        int  wr_delay;
        bit  wr_req_seen;
        mem_rd_ack  = 1'b0;
        mem_wr_ack  = 1'b0;
        mem_rd_line = '0;
        rd_delay    = -1;
        wr_delay    = -1;
        wr_req_seen = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            mem_rd_ack = 1'b0;
            mem_wr_ack = 1'b0;
            if (mem_wr_req === 1'b1 && !wr_req_seen) begin
                wb_count++;
            end
            wr_req_seen = (mem_wr_req === 1'b1);
            if (mem_wr_req === 1'b1) begin
                if (wr_delay < 0) begin
                    wr_delay = $unsigned($random(seed)) % 4;
                end
                if (wr_delay == 0) begin
                    store_line(mem_wr_addr, mem_wr_line);
                    mem_wr_ack = 1'b1;
                    wr_delay   = -1;
                end else begin
                    wr_delay--;
                end
            end
            if (mem_rd_req === 1'b1) begin
                if (rd_delay < 0) begin
                    rd_delay = $unsigned($random(seed)) % 4;
                end
                if (rd_delay == 0) begin
                    mem_rd_line = fetch_line(mem_rd_addr);
                    mem_rd_ack  = 1'b1;
                    rd_delay    = -1;
                end else begin
                    rd_delay--;
                end
            end
        end
    end

    // Responses are matched in request order
    initial begin
        int latency;
        forever begin
            @(negedge clk);
            if (!rst && resp_valid === 1'b1) begin
                if (exp_rdata.size() == 0) begin
                    errors++;
                    $display("a response arrived at %0t with no request outstanding", $time);
                end else begin
                    check_value("resp_rdata", resp_rdata, exp_rdata.pop_front());
                    check_value("write_back_count", wb_count, exp_wb.pop_front());
                    // The response is taken at the rising edge that follows this sample
                    latency = cycle_count + 1 - exp_cycle.pop_front();
                    if (exp_hit.pop_front()) begin
                        check_value("resp_latency", latency, 2);
                    end else begin
                        check_value("resp_latency_over_2", latency > 2, 1);
                    end
                    resp_count++;
                end
            end
        end
    end

    task automatic issue_request(input logic write, input addr_t addr, input word_t wdata,
                                 input strb_t strb, output bit accepted);
        int waited;
        waited    = 0;
        req_valid = 1'b1;
        req_write = write;
        req_addr  = addr;
        req_wdata = wdata;
        req_wstrb = strb;
        @(negedge clk);
        while (!req_ready && waited < 200) begin
            @(negedge clk);
            waited++;
        end
        accepted = (req_ready === 1'b1);
        if (accepted) begin
            @(posedge clk);
            #1;
        end
        req_valid = 1'b0;
    endtask

    task automatic skip_line(input int fd);
        int ch;
        ch = $fgetc(fd);
        while (ch != "\n" && ch != -1) begin
            ch = $fgetc(fd);
        end
    endtask

    task automatic report_and_finish();
        $display("closing: %0d errors, %0d requests, %0d responses, %0d write-backs",
                 errors, req_count, resp_count, wb_count);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    initial begin
        int          fd;
        int          code;
        int          waited;
        bit          run_ok;
        bit          accepted;
        logic [7:0]  op;
        addr_t       addr;
        word_t       wdata;
        strb_t       strb;
        word_t       rdata;
        logic [31:0] hit;
        logic [31:0] wb;
        $timeformat(-9, 0, " ns", 0);
        rst       = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        req_wstrb = '0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_value("req_ready", req_ready, 1);
        check_value("resp_valid", resp_valid, 0);
        check_value("mem_rd_req", mem_rd_req, 0);
        check_value("mem_wr_req", mem_wr_req, 0);
        @(posedge clk);
        #1;

        run_ok = 1'b1;
        fd = $fopen("dcache_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open dcache_golden.txt for reading");
            errors++;
            run_ok = 1'b0;
        end
        while (run_ok) begin
            code = $fscanf(fd, " %c", op);
            if (code != 1) begin
                break;
            end
            if (op == "#") begin
                skip_line(fd);
            end else begin
                code = $fscanf(fd, "%h %h %h %h %h %h", addr, wdata, strb, rdata, hit, wb);
                if (code != 6 || (op != "L" && op != "S")) begin
                    $display("golden file entry after request %0d is malformed", req_count);
                    errors++;
                    run_ok = 1'b0;
                end else begin
                    issue_request(op == "S", addr, wdata, strb, accepted);
                    if (!accepted) begin
                        $display("request %0d was not accepted within 200 cycles", req_count);
                        errors++;
                        run_ok = 1'b0;
                    end else begin
                        exp_rdata.push_back(rdata);
                        exp_hit.push_back(hit[0]);
                        exp_wb.push_back(wb);
                        exp_cycle.push_back(cycle_count);
                        req_count++;
                    end
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        waited = 0;
        while (run_ok && exp_rdata.size() != 0 && waited < 200) begin
            @(posedge clk);
            waited++;
        end
        if (run_ok && exp_rdata.size() != 0) begin
            $display("%0d responses still missing after 200 cycles", exp_rdata.size());
            errors++;
        end
        // Any extra response in the quiet cycles is flagged by the monitor
        repeat (10) @(posedge clk);
        check_value("response_count", resp_count, req_count);
        report_and_finish();
    end

endmodule

`default_nettype wire

//--- dcache_golden.txt
# op addr wdata strb rdata hit wb, all hex; op L is a load and S a store
# hit 1 means a response 2 cycles after acceptance, wb is write-backs seen at the response
L 00000024 00000000 0 00000024 0 0
L 00000038 00000000 0 00000038 1 0
L 0000003C 00000000 0 0000003C 1 0
S 00000028 AABBCCDD 3 00000000 1 0
S 00000028 11223344 8 00000000 1 0
L 00000028 00000000 0 1100CCDD 1 0
S 00000104 55667788 6 00000000 0 0
L 00000104 00000000 0 00667704 1 0
S 10000064 DEADBEEF F 00000000 0 0
L 10000868 00000000 0 10000868 0 0
L 1000106C 00000000 0 1000106C 0 1
L 10000064 00000000 0 DEADBEEF 0 1
L 10000870 00000000 0 10000870 0 1
L 10001060 00000000 0 10001060 0 1
S 0000083C 0BADF00D F 00000000 0 1
L 00001024 00000000 0 00001024 0 2
L 00000028 00000000 0 1100CCDD 0 3
L 0000083C 00000000 0 0BADF00D 0 3
L 00000024 00000000 0 00000024 1 3
L 00000838 00000000 0 00000838 1 3
S 00000024 12345678 1 00000000 1 3
L 00000024 00000000 0 00000078 1 3
L 00000904 00000000 0 00000904 0 3
L 00001104 00000000 0 00001104 0 4
L 00000104 00000000 0 00667704 0 4
L 10000064 00000000 0 DEADBEEF 0 4

//--- build.f
dcache_pkg.sv
dcache_way_ram.sv
dcache_request_stage.sv
dcache_hit_stage.sv
dcache_refill.sv
dcache_top.sv
dcache_tb.sv
